// File: all.f
+incdir+.
core_pkg.sv
ex_mem_if.sv
reg_file.sv
decode_execute.sv
execution_registers.sv
memory_stage.sv
core_top.sv
tb_core.sv

// File: Makefile
# Verilator lint, build and simulation of the pipeline back end

VERILATOR ?= verilator
TOP ?= tb_core
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert
PASS_TEXT ?= Simulation passed

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Status comes from the search for the pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_core.sv
// Testbench for the pipeline back end
// Clock, reset, Wishbone memory slave, reference model, stimulus, assertions
`timescale 1ns/10ps
`include "core_defs.svh"

module tb_core;

  // About 140 instructions at up to 6 cycles each, with a wide margin
  localparam int MAX_CYCLES = 4000;
  localparam int RANDOM_OPS = 100;

  logic clk;
  logic rst;
  logic issue_valid;
  logic [31:0] issue_instr;
  logic issue_ready;
  logic retire_valid, retire_we;
  logic [4:0] retire_rd;
  logic [31:0] retire_data;
  logic wb_cyc, wb_stb, wb_we, wb_ack;
  logic [31:0] wb_adr, wb_dat_w, wb_dat_r;
  logic [3:0] wb_sel;
  int cycles;

  // Architectural state of the reference model
  logic [31:0] model_regs [0:31];
  logic [31:0] model_mem [0:255];
  logic [31:0] slave_mem [0:255];

  // Expected retires and bus accesses, both in issue order
  logic [4:0] exp_rd [0:255];
  logic exp_we [0:255];
  logic [31:0] exp_data [0:255];
  logic [31:0] exp_adr [0:255];
  logic [3:0] exp_sel [0:255];
  logic exp_bwe [0:255];
  logic [31:0] exp_wdat [0:255];
  logic [7:0] n_exp, n_bus, retire_idx, bus_idx;
  logic [4:0] head_rd;
  logic head_we, head_bwe;
  logic [31:0] head_data, head_adr, head_wdat;
  logic [3:0] head_sel;

  core_top dut0 (.clk, .rst, .issue_valid, .issue_instr, .issue_ready, .retire_valid,
    .retire_rd, .retire_data, .retire_we, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel,
    .wb_dat_w, .wb_dat_r, .wb_ack);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
      input logic [31:0] expected);
    $display("mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
    abort_run();
  endtask

  task automatic report_error(input string what);
    $display("error at %0t: %s", $time, what);
    abort_run();
  endtask

  // Distinct value at every word address
  function automatic logic [31:0] fill_word(input int i);
    return 32'h9E37_79B9 * 32'(i + 1);
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2, input int rs1,
      input logic [2:0] f3, input int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `OP_REG};
  endfunction

  function automatic logic [31:0] i_type(input int imm, input int rs1, input logic [2:0] f3,
      input int rd, input logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1,
      input logic [2:0] f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], `OP_STORE};
  endfunction

  task automatic expect_bus(input logic [31:0] adr, input logic [3:0] sel, input logic we,
      input logic [31:0] wdat);
    exp_adr[n_bus] = adr;
    exp_sel[n_bus] = sel;
    exp_bwe[n_bus] = we;
    exp_wdat[n_bus] = wdat;
    n_bus = n_bus + 8'd1;
  endtask

  // Architectural effect of one accepted instruction
  task automatic model_step(input logic [31:0] w);
    logic [2:0] f3;
    logic [4:0] rd;
    logic [31:0] a, b, addr, word, val;
    logic [7:0] lane_byte;
    logic we, byte_op;
    f3 = w[14:12];
    rd = w[11:7];
    a = model_regs[w[19:15]];
    b = model_regs[w[24:20]];
    byte_op = f3 == `F3_BYTE;
    val = '0;
    we = 1'b0;
    case (w[6:0])
      `OP_REG:
      begin
        we = 1'b1;
        case (f3)
          `F3_AND: val = a & b;
          `F3_OR: val = a | b;
          default: val = (w[31:25] == `F7_SUB) ? a - b : a + b;
        endcase
      end
      `OP_IMM:
      begin
        we = 1'b1;
        val = a + {{20{w[31]}}, w[31:20]};
      end
      `OP_LOAD:
      begin
        we = 1'b1;
        addr = a + {{20{w[31]}}, w[31:20]};
        word = model_mem[addr[9:2]];
        lane_byte = word[{addr[1:0], 3'b000} +: 8];
        val = byte_op ? {{24{lane_byte[7]}}, lane_byte} : word;
        expect_bus(addr, byte_op ? 4'b0001 << addr[1:0] : 4'hF, 1'b0, '0);
      end
      `OP_STORE:
      begin
        addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
        if (byte_op)
          model_mem[addr[9:2]][{addr[1:0], 3'b000} +: 8] = b[7:0];
        else
          model_mem[addr[9:2]] = b;
        // Byte stores carry the byte on every lane
        expect_bus(addr, byte_op ? 4'b0001 << addr[1:0] : 4'hF, 1'b1,
          byte_op ? {4{b[7:0]}} : b);
      end
      // Anything else retires without a write
      default: we = 1'b0;
    endcase
    if (we && rd != '0)
      model_regs[rd] = val;
    exp_rd[n_exp] = rd;
    exp_we[n_exp] = we;
    exp_data[n_exp] = val;
    n_exp = n_exp + 8'd1;
  endtask

  // Hold the word on the port until the DUT takes it
  task automatic issue(input logic [31:0] w);
    issue_valid <= 1'b1;
    issue_instr <= w;
    @(posedge clk);
    while (!issue_ready)
      @(posedge clk);
    model_step(w);
  endtask

  task automatic idle_cycle();
    issue_valid <= 1'b0;
    @(posedge clk);
  endtask

  // Wishbone slave, registered ack after 0 to 3 extra wait cycles
  initial
  begin
    logic [7:0] idx;
    int wait_left;
    wb_ack <= 1'b0;
    wb_dat_r <= '0;
    wait_left = 0;
    for (int i = 0; i < 256; i++)
      slave_mem[i[7:0]] = fill_word(i);
    forever
    begin
      @(posedge clk);
      idx = wb_adr[9:2];
      if (wb_ack)
      begin
        wb_ack <= 1'b0;
        wait_left = $urandom_range(3, 0);
      end
      else if (wb_cyc && wb_stb)
      begin
        if (wait_left > 0)
          wait_left = wait_left - 1;
        else
        begin
          wb_ack <= 1'b1;
          if (wb_we)
          begin
            for (int b = 0; b < 4; b++)
              if (wb_sel[b])
                slave_mem[idx][b*8 +: 8] = wb_dat_w[b*8 +: 8];
          end
          else
            wb_dat_r <= slave_mem[idx];
        end
      end
    end
  end

  // Retire and ack counters point at the next expected entry
  always @(posedge clk)
  begin
    if (rst)
    begin
      retire_idx <= '0;
      bus_idx <= '0;
    end
    else
    begin
      if (retire_valid)
        retire_idx <= retire_idx + 8'd1;
      if (wb_cyc && wb_ack)
        bus_idx <= bus_idx + 8'd1;
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
      report_error("timeout, the pipeline stopped making progress");
  end

  assign head_rd = exp_rd[retire_idx];
  assign head_we = exp_we[retire_idx];
  assign head_data = exp_data[retire_idx];
  assign head_adr = exp_adr[bus_idx];
  assign head_sel = exp_sel[bus_idx];
  assign head_bwe = exp_bwe[bus_idx];
  assign head_wdat = exp_wdat[bus_idx];

  a_retire_count: assert property (@(posedge clk) disable iff (rst)
    retire_valid |-> retire_idx < n_exp)
    else report_error("retire with no matching issue");
  a_retire_rd: assert property (@(posedge clk) disable iff (rst)
    retire_valid |-> retire_rd == head_rd)
    else report_mismatch("retire_rd", 32'($sampled(retire_rd)), 32'($sampled(head_rd)));
  a_retire_we: assert property (@(posedge clk) disable iff (rst)
    retire_valid |-> retire_we == head_we)
    else report_mismatch("retire_we", 32'($sampled(retire_we)), 32'($sampled(head_we)));
  // Data only matters when the retire writes a register
  a_retire_data: assert property (@(posedge clk) disable iff (rst)
    (retire_valid && head_we) |-> retire_data == head_data)
    else report_mismatch("retire_data", $sampled(retire_data), $sampled(head_data));

  a_bus_count: assert property (@(posedge clk) disable iff (rst)
    (wb_cyc && wb_ack) |-> bus_idx < n_bus)
    else report_error("Wishbone access with no memory instruction behind it");
  a_bus_adr: assert property (@(posedge clk) disable iff (rst)
    (wb_cyc && wb_ack) |-> wb_adr == head_adr)
    else report_mismatch("wb_adr", $sampled(wb_adr), $sampled(head_adr));
  a_bus_sel: assert property (@(posedge clk) disable iff (rst)
    (wb_cyc && wb_ack) |-> wb_sel == head_sel)
    else report_mismatch("wb_sel", 32'($sampled(wb_sel)), 32'($sampled(head_sel)));
  a_bus_we: assert property (@(posedge clk) disable iff (rst)
    (wb_cyc && wb_ack) |-> wb_we == head_bwe)
    else report_mismatch("wb_we", 32'($sampled(wb_we)), 32'($sampled(head_bwe)));
  // Store data on the bus, replicated for byte stores
  a_bus_dat: assert property (@(posedge clk) disable iff (rst)
    (wb_cyc && wb_ack && wb_we) |-> wb_dat_w == head_wdat)
    else report_mismatch("wb_dat_w", $sampled(wb_dat_w), $sampled(head_wdat));
  // Request frozen from first stb to ack
  a_bus_hold: assert property (@(posedge clk) disable iff (rst)
    (wb_cyc && wb_stb && !wb_ack) |=> (wb_cyc && wb_stb && $stable(wb_adr) &&
      $stable(wb_sel) && $stable(wb_we)))
    else report_error("Wishbone request changed or dropped before ack");

  a_reset_ready: assert property (@(posedge clk) rst |-> !issue_ready)
    else report_error("issue_ready high during reset");
  a_reset_idle: assert property (@(posedge clk) rst |=> (!retire_valid && !wb_cyc))
    else report_error("retire_valid or wb_cyc high after a reset cycle");

  initial
  begin
    int kind;
    int rd;
    int rs1;
    int rs2;
    void'($urandom(48641));
    rst <= 1'b1;
    issue_valid <= 1'b0;
    issue_instr <= '0;
    n_exp = '0;
    n_bus = '0;
    model_regs[0] = '0;
    for (int i = 0; i < 256; i++)
      model_mem[i[7:0]] = fill_word(i);
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // Known values in x1 to x15
    for (int r = 1; r < 16; r++)
      issue(i_type(r * 37 + 5, 0, `F3_ADD, r, `OP_IMM));
    // x0 drops the write and still reads zero
    issue(i_type(5, 0, `F3_ADD, 0, `OP_IMM));
    issue(r_type(7'd0, 0, 0, `F3_ADD, 16));
    // Back-to-back chain through the forwarding paths
    issue(r_type(7'd0, 2, 1, `F3_ADD, 17));
    issue(r_type(`F7_SUB, 3, 17, `F3_ADD, 18));
    issue(r_type(7'd0, 17, 18, `F3_AND, 19));
    issue(r_type(7'd0, 4, 19, `F3_OR, 20));
    issue(i_type(-7, 20, `F3_ADD, 20, `OP_IMM));
    issue(s_type(64, 17, 0, `F3_WORD));
    issue(i_type(64, 0, `F3_WORD, 21, `OP_LOAD));
    // Byte lanes through a base register
    issue(i_type(128, 0, `F3_ADD, 22, `OP_IMM));
    issue(s_type(1, 18, 22, `F3_BYTE));
    issue(s_type(6, 19, 22, `F3_BYTE));
    issue(i_type(1, 22, `F3_BYTE, 23, `OP_LOAD));
    issue(i_type(0, 22, `F3_WORD, 24, `OP_LOAD));
    issue(i_type(6, 22, `F3_BYTE, 25, `OP_LOAD));
    // Load-use on rs1, then on rs2
    issue(i_type(64, 0, `F3_WORD, 26, `OP_LOAD));
    issue(r_type(7'd0, 1, 26, `F3_ADD, 27));
    issue(i_type(1, 22, `F3_BYTE, 28, `OP_LOAD));
    issue(r_type(`F7_SUB, 28, 2, `F3_ADD, 29));
    // JAL, outside the subset
    issue(32'h0000_006F);

    // Random mix over x0 to x15 with gaps in the issue stream
    for (int n = 0; n < RANDOM_OPS; n++)
    begin
      kind = $urandom_range(8, 0);
      rd = $urandom_range(15, 0);
      rs1 = $urandom_range(15, 1);
      rs2 = $urandom_range(15, 1);
      if ($urandom_range(3, 0) == 0)
        idle_cycle();
      case (kind)
        0: issue(r_type(7'd0, rs2, rs1, `F3_ADD, rd));
        1: issue(r_type(`F7_SUB, rs2, rs1, `F3_ADD, rd));
        2: issue(r_type(7'd0, rs2, rs1, `F3_AND, rd));
        3: issue(r_type(7'd0, rs2, rs1, `F3_OR, rd));
        4: issue(i_type($urandom_range(4095, 0), rs1, `F3_ADD, rd, `OP_IMM));
        5: issue(i_type(4 * $urandom_range(255, 0), 0, `F3_WORD, rd, `OP_LOAD));
        6: issue(s_type(4 * $urandom_range(255, 0), rs2, 0, `F3_WORD));
        7: issue(i_type($urandom_range(1023, 0), 0, `F3_BYTE, rd, `OP_LOAD));
        default: issue(s_type($urandom_range(1023, 0), rs2, 0, `F3_BYTE));
      endcase
    end
    issue_valid <= 1'b0;

    // Drain, then make sure nothing extra shows up
    while (retire_idx != n_exp)
      @(posedge clk);
    repeat (8) @(posedge clk);
    if (retire_idx == n_exp && bus_idx == n_bus)
    begin
      $display("Simulation passed");
      $finish;
    end
    else
      report_error("retire or bus access count differs from issue count");
  end

endmodule

// File: core_top.sv
// Top level of the pipeline back end
// Register file, decode/execute, execution register and memory stage
`timescale 1ns/10ps
`include "core_defs.svh"

module core_top (
  input  logic clk,
  input  logic rst,
  input  logic issue_valid,
  input  logic [`WORD_WIDTH-1:0] issue_instr,
  output logic issue_ready,
  output logic retire_valid,
  output logic [`REG_INDEX_WIDTH-1:0] retire_rd,
  output logic [`WORD_WIDTH-1:0] retire_data,
  output logic retire_we,
  output logic wb_cyc,
  output logic wb_stb,
  output logic wb_we,
  output logic [`WORD_WIDTH-1:0] wb_adr,
  output logic [`WORD_WIDTH/8-1:0] wb_sel,
  output logic [`WORD_WIDTH-1:0] wb_dat_w,
  input  logic [`WORD_WIDTH-1:0] wb_dat_r,
  input  logic wb_ack
);

  logic [`REG_INDEX_WIDTH-1:0] rf_rs1, rf_rs2, ex_rd;
  logic [`WORD_WIDTH-1:0] rf_rs1_data, rf_rs2_data, ex_result, ex_store_data;
  logic ex_valid, ex_mem_read, ex_mem_write, ex_byte_op, ex_reg_write;

  ex_mem_if exm ();

  // Retire port doubles as the writeback port
  reg_file rf0 (.clk, .rst, .rs1(rf_rs1), .rs2(rf_rs2), .rs1_data(rf_rs1_data),
    .rs2_data(rf_rs2_data), .we(retire_we), .wr_rd(retire_rd), .wr_data(retire_data));

  decode_execute dx0 (.clk, .rst, .issue_valid, .issue_instr, .issue_ready,
    .rf_rs1, .rf_rs2, .rf_rs1_data, .rf_rs2_data, .exm(exm.ex),
    .ex_valid, .ex_mem_read, .ex_mem_write, .ex_byte_op, .ex_reg_write,
    .ex_rd, .ex_result, .ex_store_data);

  execution_registers xr0 (.clk, .rst, .ex_valid, .ex_mem_read, .ex_mem_write,
    .ex_byte_op, .ex_reg_write, .ex_rd, .ex_result, .ex_store_data, .exm(exm.ex));

  memory_stage ms0 (.clk, .rst, .exm(exm.mem), .wb_cyc, .wb_stb, .wb_we, .wb_adr,
    .wb_sel, .wb_dat_w, .wb_dat_r, .wb_ack, .retire_valid, .retire_rd,
    .retire_data, .retire_we);

endmodule

// File: memory_stage.sv
// Memory stage
// Wishbone classic master, byte lanes, LB sign extension, retire register
`timescale 1ns/10ps
`include "core_defs.svh"

module memory_stage (
  input  logic clk,
  input  logic rst,
  ex_mem_if.mem exm,
  output logic wb_cyc,
  output logic wb_stb,
  output logic wb_we,
  output logic [`WORD_WIDTH-1:0] wb_adr,
  output logic [`WORD_WIDTH/8-1:0] wb_sel,
  output logic [`WORD_WIDTH-1:0] wb_dat_w,
  input  logic [`WORD_WIDTH-1:0] wb_dat_r,
  input  logic wb_ack,
  output logic retire_valid,
  output logic [`REG_INDEX_WIDTH-1:0] retire_rd,
  output logic [`WORD_WIDTH-1:0] retire_data,
  output logic retire_we
);

  localparam int SEL_WIDTH = `WORD_WIDTH / 8;

  logic mem_op, bus_done, cyc_q;
  logic [1:0] lane;
  logic [7:0] load_byte;
  logic [`WORD_WIDTH-1:0] load_value;

  assign mem_op = exm.valid && (exm.mem_read || exm.mem_write);
  assign bus_done = cyc_q && wb_ack;

  // Non-memory entries and bubbles pass straight through
  assign exm.advance = !exm.valid || !mem_op || bus_done;

  // Cycle opens for a memory entry, closes after ack
  always_ff @(posedge clk)
  begin
    if (rst)
      cyc_q <= 1'b0;
    else if (bus_done)
      cyc_q <= 1'b0;
    else if (mem_op)
      cyc_q <= 1'b1;
  end

  assign wb_cyc = cyc_q;
  assign wb_stb = cyc_q;

  // Held by the execution register until ack
  assign lane = exm.result[1:0];
  assign wb_adr = exm.result;
  assign wb_we = exm.mem_write;
  assign wb_sel = exm.byte_op ? (SEL_WIDTH'(1) << lane) : '1;
  // Byte store copies the byte to every lane
  assign wb_dat_w = exm.byte_op ? {SEL_WIDTH{exm.store_data[7:0]}} : exm.store_data;

  assign load_byte = wb_dat_r[lane*8 +: 8];
  assign load_value = exm.byte_op ? {{(`WORD_WIDTH-8){load_byte[7]}}, load_byte} : wb_dat_r;

  // Retire flags, also the register file write enable
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      retire_valid <= 1'b0;
      retire_we <= 1'b0;
    end
    else
    begin
      retire_valid <= exm.valid && exm.advance;
      retire_we <= exm.valid && exm.advance && exm.reg_write;
    end
  end

  always_ff @(posedge clk)
  begin
    if (exm.advance)
    begin
      retire_rd <= exm.rd;
      retire_data <= exm.mem_read ? load_value : exm.result;
    end
  end

  // Request fields frozen until the slave acks
  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    (wb_cyc && wb_stb && !wb_ack) |=> (wb_cyc && $stable(wb_adr) &&
      $stable(wb_we) && $stable(wb_sel)));

endmodule

// File: execution_registers.sv
// Execute/memory pipeline register
// Loads on advance, holds the whole entry while memory is busy
`timescale 1ns/10ps
`include "core_defs.svh"

module execution_registers (
  input  logic clk,
  input  logic rst,
  input  logic ex_valid,
  input  logic ex_mem_read,
  input  logic ex_mem_write,
  input  logic ex_byte_op,
  input  logic ex_reg_write,
  input  logic [`REG_INDEX_WIDTH-1:0] ex_rd,
  input  logic [`WORD_WIDTH-1:0] ex_result,
  input  logic [`WORD_WIDTH-1:0] ex_store_data,
  ex_mem_if.ex exm
);

  // Valid and access kind
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      exm.valid <= 1'b0;
      exm.mem_read <= 1'b0;
      exm.mem_write <= 1'b0;
      exm.reg_write <= 1'b0;
    end
    else if (exm.advance)
    begin
      // Bubble when decode did not accept
      exm.valid <= ex_valid;
      exm.mem_read <= ex_mem_read;
      exm.mem_write <= ex_mem_write;
      exm.reg_write <= ex_reg_write;
    end
  end

  // Payload
  always_ff @(posedge clk)
  begin
    if (exm.advance)
    begin
      exm.byte_op <= ex_byte_op;
      exm.rd <= ex_rd;
      exm.result <= ex_result;
      exm.store_data <= ex_store_data;
    end
  end

  // A held entry would drop any new instruction offered now
  a_no_issue_on_hold: assert property (@(posedge clk) disable iff (rst)
    !exm.advance |-> !ex_valid);

endmodule

// File: decode_execute.sv
// Combined decode and execute stage
// Immediate build, operand forwarding, load-use stall, ALU, issue handshake
`timescale 1ns/10ps
`include "core_defs.svh"

module decode_execute import core_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic issue_valid,
  input  instr_t issue_instr,
  output logic issue_ready,
  output logic [`REG_INDEX_WIDTH-1:0] rf_rs1,
  output logic [`REG_INDEX_WIDTH-1:0] rf_rs2,
  input  logic [`WORD_WIDTH-1:0] rf_rs1_data,
  input  logic [`WORD_WIDTH-1:0] rf_rs2_data,
  ex_mem_if.ex exm,
  output logic ex_valid,
  output logic ex_mem_read,
  output logic ex_mem_write,
  output logic ex_byte_op,
  output logic ex_reg_write,
  output logic [`REG_INDEX_WIDTH-1:0] ex_rd,
  output logic [`WORD_WIDTH-1:0] ex_result,
  output logic [`WORD_WIDTH-1:0] ex_store_data
);

  r_fields_t r;
  s_fields_t s;
  logic is_reg, is_imm, is_load, is_store, supported, uses_rs2;
  logic fwd_ok, load_use, accept;
  logic [`WORD_WIDTH-1:0] imm_i, imm_s, op_a, op_b, fwd_rs2;

  assign r = issue_instr.r_fields;
  assign s = issue_instr.s_fields;

  assign is_reg = r.opcode == `OP_REG;
  assign is_imm = r.opcode == `OP_IMM;
  assign is_load = r.opcode == `OP_LOAD;
  assign is_store = r.opcode == `OP_STORE;
  assign uses_rs2 = is_reg || is_store;

  // Anything outside the subset goes down the pipe as a no-op
  assign supported =
    (is_reg && r.funct3 == `F3_ADD && (r.funct7 == '0 || r.funct7 == `F7_SUB)) ||
    (is_reg && (r.funct3 == `F3_AND || r.funct3 == `F3_OR) && r.funct7 == '0) ||
    (is_imm && r.funct3 == `F3_ADD) ||
    ((is_load || is_store) && (r.funct3 == `F3_BYTE || r.funct3 == `F3_WORD));

  // Sign-extended immediates from the two views
  assign imm_i = {{(`WORD_WIDTH-12){r.funct7[6]}}, r.funct7, r.rs2};
  assign imm_s = {{(`WORD_WIDTH-12){s.imm_hi[6]}}, s.imm_hi, s.imm_lo};

  assign rf_rs1 = r.rs1;
  assign rf_rs2 = r.rs2;

  // Execution register result is ready unless it is a load address
  assign fwd_ok = exm.valid && exm.reg_write && !exm.mem_read && exm.rd != '0;
  assign op_a = (fwd_ok && exm.rd == r.rs1) ? exm.result : rf_rs1_data;
  assign fwd_rs2 = (fwd_ok && exm.rd == r.rs2) ? exm.result : rf_rs2_data;
  assign op_b = is_reg ? fwd_rs2 : (is_store ? imm_s : imm_i);

  // Load data only exists after retire, so wait for it
  assign load_use = issue_valid && exm.valid && exm.mem_read && exm.rd != '0 &&
    (exm.rd == r.rs1 || (uses_rs2 && exm.rd == r.rs2));

  assign issue_ready = !rst && exm.advance && !load_use;
  assign accept = issue_valid && issue_ready;

  always_comb
  begin
    ex_result = op_a + op_b;
    if (is_reg)
    begin
      case (r.funct3)
        `F3_AND: ex_result = op_a & op_b;
        `F3_OR: ex_result = op_a | op_b;
        default: ex_result = (r.funct7 == `F7_SUB) ? op_a - op_b : op_a + op_b;
      endcase
    end
  end

  // Control is qualified here, a stall sends a bubble
  assign ex_valid = accept;
  assign ex_mem_read = accept && supported && is_load;
  assign ex_mem_write = accept && supported && is_store;
  assign ex_reg_write = accept && supported && (is_reg || is_imm || is_load);
  assign ex_byte_op = r.funct3 == `F3_BYTE;
  assign ex_rd = r.rd;
  assign ex_store_data = fwd_rs2;

  // Stall lasts only until the load leaves for retire
  a_stall_releases: assert property (@(posedge clk) disable iff (rst)
    (load_use && exm.advance) |=> !load_use);

endmodule

// File: reg_file.sv
// 32-entry register file
// Two combinational read ports, one write port with write-through bypass
`timescale 1ns/10ps
`include "core_defs.svh"

module reg_file (
  input  logic clk,
  input  logic rst,
  input  logic [`REG_INDEX_WIDTH-1:0] rs1,
  input  logic [`REG_INDEX_WIDTH-1:0] rs2,
  output logic [`WORD_WIDTH-1:0] rs1_data,
  output logic [`WORD_WIDTH-1:0] rs2_data,
  input  logic we,
  input  logic [`REG_INDEX_WIDTH-1:0] wr_rd,
  input  logic [`WORD_WIDTH-1:0] wr_data
);

  logic [`WORD_WIDTH-1:0] regs [0:(1<<`REG_INDEX_WIDTH)-1];

  // Entry zero is cleared in reset and never written
  always_ff @(posedge clk)
  begin
    if (rst)
      regs[0] <= '0;
    else if (we && wr_rd != '0)
      regs[wr_rd] <= wr_data;
  end

  // Same-cycle write shows up on the read ports
  // This is the writeback forwarding path
  always_comb
  begin
    if (rs1 == '0)
      rs1_data = '0;
    else if (we && wr_rd == rs1)
      rs1_data = wr_data;
    else
      rs1_data = regs[rs1];

    if (rs2 == '0)
      rs2_data = '0;
    else if (we && wr_rd == rs2)
      rs2_data = wr_data;
    else
      rs2_data = regs[rs2];
  end

  // Retire that targets x0 leaves the stored entry at zero
  a_x0_stays_zero: assert property (@(posedge clk) disable iff (rst)
    (we && wr_rd == '0) |=> regs[0] == '0);

endmodule

// File: ex_mem_if.sv
// Execute/memory stage link
// Entry fields from the execution register, advance back from memory
`timescale 1ns/10ps
`include "core_defs.svh"

interface ex_mem_if;

  // Entry held in the execution register
  logic valid;
  logic mem_read;
  logic mem_write;
  logic byte_op;
  logic reg_write;
  logic [`REG_INDEX_WIDTH-1:0] rd;
  // ALU value, or effective address for memory ops
  logic [`WORD_WIDTH-1:0] result;
  logic [`WORD_WIDTH-1:0] store_data;

  // Memory stage can take the entry this cycle
  logic advance;

  // Register side, decode also reads result and rd here
  modport ex (
    output valid, mem_read, mem_write, byte_op, reg_write, rd, result, store_data,
    input  advance
  );

  modport mem (
    input  valid, mem_read, mem_write, byte_op, reg_write, rd, result, store_data,
    output advance
  );

endinterface

// File: core_pkg.sv
// Instruction word types shared by the pipeline
// Register layout, store layout and the union that overlays them
`include "core_defs.svh"

package core_pkg;

  // R-type view, also used for I-type fields
  // I immediate is funct7 and rs2 taken together
  typedef struct packed {
    logic [6:0] funct7;
    logic [`REG_INDEX_WIDTH-1:0] rs2;
    logic [`REG_INDEX_WIDTH-1:0] rs1;
    logic [2:0] funct3;
    logic [`REG_INDEX_WIDTH-1:0] rd;
    logic [6:0] opcode;
  } r_fields_t;

  // S-type view, immediate split around the source fields
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [`REG_INDEX_WIDTH-1:0] rs2;
    logic [`REG_INDEX_WIDTH-1:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fields_t;

  // One 32-bit word, decoded either way by opcode
  typedef union packed {
    r_fields_t r_fields;
    s_fields_t s_fields;
  } instr_t;

endpackage

// File: core_defs.svh
// Width, opcode and funct3 macros for the pipeline back end
// Opcodes and function codes follow the RV32I base encoding
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Data path and register index widths
`define WORD_WIDTH 32
`define REG_INDEX_WIDTH 5

// Major opcodes of the supported subset
`define OP_REG 7'b0110011
`define OP_IMM 7'b0010011
`define OP_LOAD 7'b0000011
`define OP_STORE 7'b0100011

// funct3 codes for ALU ops and memory access size
`define F3_ADD 3'b000
`define F3_AND 3'b111
`define F3_OR 3'b110
`define F3_BYTE 3'b000
`define F3_WORD 3'b010

// funct7 that turns ADD into SUB
`define F7_SUB 7'b0100000

`endif
